// File: Makefile
VERILATOR ?= verilator
TOP       ?= gpu_unit_tb
FILELIST  ?= gpu_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -x -F '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: gpu_unit.f
+incdir+include
hdl/gpu_isa_pkg.sv
hdl/gpu_wctl_pkg.sv
hdl/gpu_wctl.sv
hdl/gpu_imadd.sv
hdl/gpu_rsp_arb.sv
hdl/gpu_unit.sv
sim/gpu_unit_checker.sv
sim/gpu_unit_tb.sv

// File: hdl/gpu_imadd.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpu_config.svh"

module gpu_imadd (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         in_valid,
    output logic                        in_ready,
    input  wire gpu_isa_pkg::gpu_req_t  req,
    output logic                        out_valid,
    input  wire                         out_ready,
    output gpu_isa_pkg::gpu_commit_t    rsp
);

    logic s1_valid;
    logic s2_valid;
    logic s1_en;
    logic s2_en;

    gpu_isa_pkg::gpu_req_t                   s1_req;
    logic [`NUM_THREADS-1:0][63:0]           s1_prod;
    logic [`NUM_THREADS-1:0][63:0]           lane_shift;
    gpu_isa_pkg::word_t [`NUM_THREADS-1:0]   lane_sum;

    // a stage moves only if the one after it has room
    assign s2_en    = !s2_valid || out_ready;
    assign s1_en    = !s1_valid || s2_en;
    assign in_ready = s1_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_en)
                s1_valid <= in_valid;
            if (s2_en)
                s2_valid <= s1_valid;
        end
    end

    // stage 1: full 64-bit products per lane
    always_ff @(posedge clk) begin
        if (s1_en) begin
            s1_req <= req;
            for (int i = 0; i < `NUM_THREADS; i++)
                s1_prod[i] <= 64'(req.rs1_data[i]) * 64'(req.rs2_data[i]);
        end
    end

    // stage 2: shift by op_mod bytes then add rs3
    for (genvar i = 0; i < `NUM_THREADS; i++) begin : g_lane
        assign lane_shift[i] = s1_prod[i] >> {s1_req.op_mod, 3'b000};
        assign lane_sum[i]   = lane_shift[i][31:0] + s1_req.rs3_data[i];
    end

    always_ff @(posedge clk) begin
        if (s2_en) begin
            rsp.uuid  <= s1_req.uuid;
            rsp.wid   <= s1_req.wid;
            rsp.tmask <= s1_req.tmask;
            rsp.pc    <= s1_req.pc;
            rsp.rd    <= s1_req.rd;
            rsp.wb    <= s1_req.wb;
            rsp.data  <= lane_sum;
            rsp.eop   <= 1'b1;
        end
    end

    assign out_valid = s2_valid;

endmodule

`default_nettype wire

// File: hdl/gpu_isa_pkg.sv
`default_nettype none

`include "gpu_config.svh"

package gpu_isa_pkg;

    typedef logic [`UUID_BITS-1:0]   uuid_t;
    typedef logic [`NW_BITS-1:0]     wid_t;
    typedef logic [`NUM_THREADS-1:0] tmask_t;
    typedef logic [`NUM_WARPS-1:0]   wmask_t;
    typedef logic [`NR_BITS-1:0]     rid_t;
    typedef logic [`NB_BITS-1:0]     bar_id_t;
    typedef logic [31:0]             word_t;

    // issuing stage only sends these six
    typedef enum logic [2:0] {
        op_tmc,
        op_pred,
        op_wspawn,
        op_split,
        op_bar,
        op_imadd
    } gpu_op_e;

    typedef struct packed {
        uuid_t                        uuid;
        wid_t                         wid;
        tmask_t                       tmask;
        word_t                        pc;
        word_t                        next_pc;
        gpu_op_e                      op;
        logic [1:0]                   op_mod;
        rid_t                         rd;
        logic                         wb;
        logic [1:0]                   tid;
        word_t [`NUM_THREADS-1:0]     rs1_data;
        word_t [`NUM_THREADS-1:0]     rs2_data;
        word_t [`NUM_THREADS-1:0]     rs3_data;
    } gpu_req_t;

    typedef struct packed {
        uuid_t                        uuid;
        wid_t                         wid;
        tmask_t                       tmask;
        word_t                        pc;
        rid_t                         rd;
        logic                         wb;
        word_t [`NUM_THREADS-1:0]     data;
        logic                         eop;
    } gpu_commit_t;

endpackage

`default_nettype wire

// File: hdl/gpu_rsp_arb.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_rsp_arb (
    input  wire                             clk,
    input  wire                             rst_n,

    input  wire                             wctl_valid_in,
    output logic                            wctl_ready_in,
    input  wire gpu_isa_pkg::gpu_commit_t   wctl_rsp,
    input  wire gpu_wctl_pkg::warp_ctl_t    wctl_in,

    input  wire                             imadd_valid_in,
    output logic                            imadd_ready_in,
    input  wire gpu_isa_pkg::gpu_commit_t   imadd_rsp,

    output logic                            commit_valid,
    output gpu_isa_pkg::gpu_commit_t        commit,
    input  wire                             commit_ready,

    output logic                            wctl_valid,
    output gpu_wctl_pkg::warp_ctl_t         wctl
);

    logic wctl_won_last;
    logic is_wctl_r;
    logic load_en;
    logic pick_imadd;
    logic any_valid;

    // output register takes a new entry when empty or draining
    assign load_en   = !commit_valid || commit_ready;
    assign any_valid = wctl_valid_in || imadd_valid_in;

    // round robin, wctl goes first out of reset
    assign pick_imadd = imadd_valid_in && (!wctl_valid_in || wctl_won_last);

    assign wctl_ready_in  = load_en && !pick_imadd;
    assign imadd_ready_in = load_en && pick_imadd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wctl_won_last <= 1'b0;
            commit_valid  <= 1'b0;
            is_wctl_r     <= 1'b0;
        end else if (load_en) begin
            commit_valid <= any_valid;
            is_wctl_r    <= any_valid && !pick_imadd;
            if (any_valid)
                wctl_won_last <= !pick_imadd;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            commit <= pick_imadd ? imadd_rsp : wctl_rsp;
            wctl   <= wctl_in;
        end
    end

    // side port fires on the commit handshake of a warp-control entry
    assign wctl_valid = commit_valid && commit_ready && is_wctl_r;

endmodule

`default_nettype wire

// File: hdl/gpu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_unit (
    input  wire                         clk,
    input  wire                         rst_n,

    input  wire                         req_valid,
    output logic                        req_ready,
    input  wire gpu_isa_pkg::gpu_req_t  req,

    output logic                        commit_valid,
    input  wire                         commit_ready,
    output gpu_isa_pkg::gpu_commit_t    commit,

    output logic                        wctl_valid,
    output gpu_wctl_pkg::warp_ctl_t     wctl
);

    logic is_imadd;
    logic wctl_req_valid;
    logic wctl_req_ready;
    logic imadd_in_valid;
    logic imadd_in_ready;
    logic imadd_out_valid;
    logic imadd_out_ready;

    gpu_wctl_pkg::warp_ctl_t   wctl_dec;
    gpu_isa_pkg::gpu_commit_t  wctl_rsp;
    gpu_isa_pkg::gpu_commit_t  imadd_rsp;

    assign is_imadd       = (req.op == gpu_isa_pkg::op_imadd);
    assign wctl_req_valid = req_valid && !is_imadd;
    assign imadd_in_valid = req_valid && is_imadd;
    assign req_ready      = is_imadd ? imadd_in_ready : wctl_req_ready;

    gpu_wctl u_wctl (
        .req  (req),
        .wctl (wctl_dec)
    );

    // warp-control ops commit with no register write
    assign wctl_rsp.uuid  = req.uuid;
    assign wctl_rsp.wid   = req.wid;
    assign wctl_rsp.tmask = req.tmask;
    assign wctl_rsp.pc    = req.pc;
    assign wctl_rsp.rd    = '0;
    assign wctl_rsp.wb    = 1'b0;
    assign wctl_rsp.data  = '0;
    assign wctl_rsp.eop   = 1'b1;

    gpu_imadd u_imadd (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (imadd_in_valid),
        .in_ready  (imadd_in_ready),
        .req       (req),
        .out_valid (imadd_out_valid),
        .out_ready (imadd_out_ready),
        .rsp       (imadd_rsp)
    );

    gpu_rsp_arb u_rsp_arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .wctl_valid_in  (wctl_req_valid),
        .wctl_ready_in  (wctl_req_ready),
        .wctl_rsp       (wctl_rsp),
        .wctl_in        (wctl_dec),
        .imadd_valid_in (imadd_out_valid),
        .imadd_ready_in (imadd_out_ready),
        .imadd_rsp      (imadd_rsp),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_ready   (commit_ready),
        .wctl_valid     (wctl_valid),
        .wctl           (wctl)
    );

endmodule

`default_nettype wire

// File: hdl/gpu_wctl.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpu_config.svh"

module gpu_wctl (
    input  wire gpu_isa_pkg::gpu_req_t  req,
    output gpu_wctl_pkg::warp_ctl_t     wctl
);

    logic is_tmc;
    logic is_pred;
    logic is_wspawn;
    logic is_split;
    logic is_bar;

    gpu_isa_pkg::word_t  rs1_sel;
    gpu_isa_pkg::word_t  rs2_sel;
    gpu_isa_pkg::word_t  size_word;
    gpu_isa_pkg::tmask_t taken_tmask;
    gpu_isa_pkg::tmask_t not_taken_tmask;
    gpu_isa_pkg::tmask_t pred_tmask;
    gpu_isa_pkg::wmask_t spawn_wmask;

    assign is_tmc    = (req.op == gpu_isa_pkg::op_tmc);
    assign is_pred   = (req.op == gpu_isa_pkg::op_pred);
    assign is_wspawn = (req.op == gpu_isa_pkg::op_wspawn);
    assign is_split  = (req.op == gpu_isa_pkg::op_split);
    assign is_bar    = (req.op == gpu_isa_pkg::op_bar);

    // scalar operands come from the lane picked by tid
    assign rs1_sel = req.rs1_data[req.tid];
    assign rs2_sel = req.rs2_data[req.tid];

    for (genvar i = 0; i < `NUM_THREADS; i++) begin : g_lane
        assign taken_tmask[i]     = req.tmask[i] & (req.rs1_data[i] != '0);
        assign not_taken_tmask[i] = req.tmask[i] & (req.rs1_data[i] == '0);
    end

    for (genvar i = 0; i < `NUM_WARPS; i++) begin : g_warp
        assign spawn_wmask[i] = (rs1_sel > gpu_isa_pkg::word_t'(i));
    end

    // no lane taken keeps the current mask
    assign pred_tmask = (taken_tmask != '0) ? taken_tmask : req.tmask;
    assign size_word  = rs2_sel - 32'd1;

    assign wctl.wid = req.wid;

    assign wctl.tmc.valid = is_tmc | is_pred;
    assign wctl.tmc.tmask = is_pred ? pred_tmask : rs1_sel[`NUM_THREADS-1:0];

    assign wctl.wspawn.valid = is_wspawn;
    assign wctl.wspawn.wmask = spawn_wmask;
    assign wctl.wspawn.pc    = rs2_sel;

    assign wctl.split.valid      = is_split;
    assign wctl.split.diverged   = (|taken_tmask) & (|not_taken_tmask);
    assign wctl.split.then_tmask = taken_tmask;
    assign wctl.split.else_tmask = not_taken_tmask;
    assign wctl.split.pc         = req.next_pc;

    assign wctl.barrier.valid   = is_bar;
    assign wctl.barrier.id      = rs1_sel[`NB_BITS-1:0];
    assign wctl.barrier.size_m1 = size_word[`NW_BITS-1:0];

endmodule

`default_nettype wire

// File: hdl/gpu_wctl_pkg.sv
`default_nettype none

package gpu_wctl_pkg;

    typedef struct packed {
        logic                  valid;
        gpu_isa_pkg::tmask_t   tmask;
    } gpu_tmc_t;

    typedef struct packed {
        logic                  valid;
        gpu_isa_pkg::wmask_t   wmask;
        gpu_isa_pkg::word_t    pc;
    } gpu_wspawn_t;

    typedef struct packed {
        logic                  valid;
        logic                  diverged;
        gpu_isa_pkg::tmask_t   then_tmask;
        gpu_isa_pkg::tmask_t   else_tmask;
        gpu_isa_pkg::word_t    pc;
    } gpu_split_t;

    // size_m1 counts warps, so it is warp-id wide
    typedef struct packed {
        logic                  valid;
        gpu_isa_pkg::bar_id_t  id;
        gpu_isa_pkg::wid_t     size_m1;
    } gpu_barrier_t;

    typedef struct packed {
        gpu_isa_pkg::wid_t     wid;
        gpu_tmc_t              tmc;
        gpu_wspawn_t           wspawn;
        gpu_split_t            split;
        gpu_barrier_t          barrier;
    } warp_ctl_t;

endpackage

`default_nettype wire

// File: include/gpu_config.svh
`ifndef GPU_CONFIG_SVH
`define GPU_CONFIG_SVH

// lanes per warp
`define NUM_THREADS 4

// warps per core
`define NUM_WARPS 4

// warp id width
`define NW_BITS 2

// barrier id width
`define NB_BITS 2

// register index width
`define NR_BITS 5

// instruction id width
`define UUID_BITS 8

`endif

// File: sim/gpu_unit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_unit_checker (
    input wire                         clk,
    input wire                         rst_n,
    input wire                         req_valid,
    input wire                         req_ready,
    input wire gpu_isa_pkg::gpu_req_t  req,
    input wire                         commit_valid,
    input wire                         commit_ready,
    input wire gpu_isa_pkg::gpu_commit_t commit,
    input wire                         wctl_valid
);

    // outputs idle right after a reset cycle
    a_reset_idle: assert property (@(posedge clk)
        !rst_n |=> !commit_valid && !wctl_valid)
        else $error("commit or side port valid after reset");

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("request changed while stalled");

    a_commit_hold: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else $error("commit changed under back-pressure");

    // issuing stage sends only the six known ops
    a_op_range: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> req.op inside {gpu_isa_pkg::op_tmc, gpu_isa_pkg::op_pred,
                                     gpu_isa_pkg::op_wspawn, gpu_isa_pkg::op_split,
                                     gpu_isa_pkg::op_bar, gpu_isa_pkg::op_imadd})
        else $error("request op out of range");

    // side port only on a warp-control entry, which never writes back
    a_side_port: assert property (@(posedge clk) disable iff (!rst_n)
        wctl_valid |-> commit_valid && commit.eop && !commit.wb
                       && commit.rd == '0 && commit.data == '0)
        else $error("side port fired on a commit that is not a warp-control entry");

endmodule

bind gpu_unit gpu_unit_checker u_checker (.*);

`default_nettype wire

// File: sim/gpu_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "gpu_config.svh"

module gpu_unit_tb;

    // 52 requests issued over all tests
    localparam int NUM_REQ        = 52;
    localparam int TIMEOUT_CYCLES = 40 * NUM_REQ + 100;

    logic clk = 1'b0;
    logic rst_n;
    logic req_valid;
    logic req_ready;
    logic commit_valid;
    logic commit_ready;
    logic wctl_valid;

    gpu_isa_pkg::gpu_req_t     req;
    gpu_isa_pkg::gpu_commit_t  commit;
    gpu_wctl_pkg::warp_ctl_t   wctl;

    gpu_isa_pkg::gpu_commit_t  wexp_q[$];
    gpu_isa_pkg::gpu_commit_t  iexp_q[$];
    gpu_wctl_pkg::warp_ctl_t   wctl_q[$];

    logic [31:0]         lfsr = 32'hbfe9_15b4;
    gpu_isa_pkg::uuid_t  next_uuid = '0;
    logic                bp_on = 1'b0;
    int                  tb_errors = 0;
    int                  mon_errors = 0;
    int                  cycles = 0;

    gpu_unit UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit),
        .wctl_valid   (wctl_valid),
        .wctl         (wctl)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [255:0] got,
                           input logic [255:0] exp, inout int count);
        if (got !== exp) begin
            count++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic gpu_isa_pkg::gpu_req_t make_req(input gpu_isa_pkg::gpu_op_e op,
                                                       input logic [1:0] mod);
        gpu_isa_pkg::gpu_req_t r;
        r.uuid = next_uuid;
        next_uuid++;
        r.wid = gpu_isa_pkg::wid_t'(rand_bits(`NW_BITS));
        r.tmask = gpu_isa_pkg::tmask_t'(rand_bits(`NUM_THREADS));
        r.pc = rand_bits(32);
        r.next_pc = r.pc + 32'd4;
        r.op = op;
        r.op_mod = mod;
        r.rd = gpu_isa_pkg::rid_t'(rand_bits(`NR_BITS));
        r.wb = (rand_bits(1) != 0);
        r.tid = 2'(rand_bits(2));
        // zero and small rs1 words exercise the taken and spawn rules
        for (int i = 0; i < `NUM_THREADS; i++) begin
            case (rand_bits(2))
                32'd0:   r.rs1_data[i] = '0;
                32'd1:   r.rs1_data[i] = rand_bits(3);
                default: r.rs1_data[i] = rand_bits(32);
            endcase
            r.rs2_data[i] = rand_bits(32);
            r.rs3_data[i] = rand_bits(32);
        end
        return r;
    endfunction

    function automatic gpu_wctl_pkg::warp_ctl_t expect_wctl(input gpu_isa_pkg::gpu_req_t r);
        gpu_wctl_pkg::warp_ctl_t w;
        gpu_isa_pkg::tmask_t     taken;
        logic [31:0]             a;
        logic [31:0]             b;
        a = r.rs1_data[r.tid];
        b = r.rs2_data[r.tid];
        for (int i = 0; i < `NUM_THREADS; i++)
            taken[i] = r.tmask[i] && (r.rs1_data[i] != '0);
        w.wid = r.wid;
        w.tmc.valid = r.op inside {gpu_isa_pkg::op_tmc, gpu_isa_pkg::op_pred};
        if (r.op == gpu_isa_pkg::op_pred)
            w.tmc.tmask = (|taken) ? taken : r.tmask;
        else
            w.tmc.tmask = a[`NUM_THREADS-1:0];
        w.wspawn.valid = (r.op == gpu_isa_pkg::op_wspawn);
        for (int i = 0; i < `NUM_WARPS; i++)
            w.wspawn.wmask[i] = (a > 32'(i));
        w.wspawn.pc = b;
        w.split.valid = (r.op == gpu_isa_pkg::op_split);
        w.split.then_tmask = taken;
        w.split.else_tmask = r.tmask & ~taken;
        w.split.diverged = (|taken) && (|(r.tmask & ~taken));
        w.split.pc = r.next_pc;
        w.barrier.valid = (r.op == gpu_isa_pkg::op_bar);
        w.barrier.id = a[`NB_BITS-1:0];
        w.barrier.size_m1 = gpu_isa_pkg::wid_t'(b - 32'd1);
        return w;
    endfunction

    function automatic gpu_isa_pkg::gpu_commit_t expect_commit(input gpu_isa_pkg::gpu_req_t r);
        gpu_isa_pkg::gpu_commit_t c;
        logic [63:0]              p;
        c.uuid = r.uuid;
        c.wid = r.wid;
        c.tmask = r.tmask;
        c.pc = r.pc;
        c.rd = '0;
        c.wb = 1'b0;
        c.data = '0;
        c.eop = 1'b1;
        if (r.op == gpu_isa_pkg::op_imadd) begin
            c.rd = r.rd;
            c.wb = r.wb;
            for (int i = 0; i < `NUM_THREADS; i++) begin
                p = 64'(r.rs1_data[i]) * 64'(r.rs2_data[i]);
                p = p >> (8 * r.op_mod);
                c.data[i] = p[31:0] + r.rs3_data[i];
            end
        end
        return c;
    endfunction

    task automatic update_ready();
        if (bp_on)
            commit_ready = (rand_bits(1) != 0);
    endtask

    // returns on the rising edge that accepts the request
    task automatic send(input gpu_isa_pkg::gpu_req_t r);
        @(negedge clk);
        update_ready();
        req = r;
        req_valid = 1'b1;
        if (r.op == gpu_isa_pkg::op_imadd) begin
            iexp_q.push_back(expect_commit(r));
        end else begin
            wexp_q.push_back(expect_commit(r));
            wctl_q.push_back(expect_wctl(r));
        end
        @(posedge clk);
        while (!req_ready) begin
            @(negedge clk);
            update_ready();
            @(posedge clk);
        end
    endtask

    task automatic drain();
        @(negedge clk);
        req_valid = 1'b0;
        while (wexp_q.size() != 0 || iexp_q.size() != 0) begin
            @(negedge clk);
            update_ready();
        end
        bp_on = 1'b0;
        commit_ready = 1'b1;
    endtask

    // source is told apart by the side port
    always @(posedge clk) begin
        if (rst_n && commit_valid && commit_ready) begin
            if (wctl_valid && wexp_q.size() != 0) begin
                compare("commit", 256'(commit), 256'(wexp_q.pop_front()), mon_errors);
                compare("wctl", 256'(wctl), 256'(wctl_q.pop_front()), mon_errors);
            end else if (!wctl_valid && iexp_q.size() != 0) begin
                compare("commit", 256'(commit), 256'(iexp_q.pop_front()), mon_errors);
            end else begin
                mon_errors++;
                $display("unexpected commit with uuid %h at %0t", commit.uuid, $time);
            end
        end
    end

    task automatic test_reset();
        repeat (5) begin
            @(posedge clk);
            compare("commit_valid", 256'(commit_valid), 256'(0), tb_errors);
            compare("wctl_valid", 256'(wctl_valid), 256'(0), tb_errors);
        end
    endtask

    task automatic test_tmc_pred();
        for (int i = 0; i < 8; i++) begin
            send(make_req(i[0] ? gpu_isa_pkg::op_pred : gpu_isa_pkg::op_tmc, 2'(i)));
            @(negedge clk);
            req_valid = 1'b0;
            @(posedge clk);
            compare("commit_valid", 256'(commit_valid), 256'(1), tb_errors);
        end
        drain();
    endtask

    task automatic test_wspawn();
        for (int i = 0; i < 4; i++)
            send(make_req(gpu_isa_pkg::op_wspawn, 2'(i)));
        drain();
    endtask

    task automatic test_split_bar();
        for (int i = 0; i < 8; i++)
            send(make_req(i[0] ? gpu_isa_pkg::op_bar : gpu_isa_pkg::op_split, 2'(i)));
        drain();
    endtask

    task automatic test_imadd();
        for (int i = 0; i < 8; i++)
            send(make_req(gpu_isa_pkg::op_imadd, 2'(i)));
        drain();
    endtask

    task automatic test_mixed();
        logic [31:0]          sel;
        logic [1:0]           mod;
        gpu_isa_pkg::gpu_op_e op;
        bp_on = 1'b1;
        for (int i = 0; i < 24; i++) begin
            sel = rand_bits(3);
            mod = 2'(rand_bits(2));
            if (sel >= 32'd5)
                op = gpu_isa_pkg::op_imadd;
            else
                op = gpu_isa_pkg::gpu_op_e'(sel[2:0]);
            send(make_req(op, mod));
        end
        drain();
    endtask

    initial begin
        rst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        commit_ready = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_tmc_pred();
        test_wspawn();
        test_split_bar();
        test_imadd();
        test_mixed();
        repeat (4) @(posedge clk);
        $display("errors: stimulus %0d, monitor %0d", tb_errors, mon_errors);
        if (tb_errors == 0 && mon_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
